// ==== source/gat_pkg.sv ====
// GAT weight stage shared types

package gat_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  parameter int DATA_WIDTH    = 8;
  parameter int WH_WIDTH      = 20;
  parameter int SCORE_WIDTH   = 32;
  // Covers the largest supported NUM_FEATURE_IN
  parameter int COL_IDX_WIDTH = 11;

  // ==========================================================================
  // Value types
  // ==========================================================================
  typedef logic signed [DATA_WIDTH-1:0]  data_t;
  typedef logic signed [WH_WIDTH-1:0]    wh_t;
  typedef logic signed [SCORE_WIDTH-1:0] score_t;

  // One nonzero element of a sparse H row
  typedef struct packed {
    data_t                    value;
    logic [COL_IDX_WIDTH-1:0] col_idx;
    logic                     last;
  } h_elem_t;

  // Weight loader FSM
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    DONE
  } loader_state_e;

endpackage

// ==== source/wgt_bram.sv ====
// Simple dual-port block memory
`timescale 1ns/100ps

module wgt_bram #(
  parameter int DATA_W = 8,
  parameter int DEPTH  = 64,
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data
);

  logic [DATA_W-1:0] mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port, one cycle after the address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== source/w_loader.sv ====
// Weight column splitter
`timescale 1ns/100ps

module w_loader #(
  parameter int NUM_FEATURE_IN  = 8,
  parameter int NUM_FEATURE_OUT = 4,
  localparam int W_SIZE      = NUM_FEATURE_IN * NUM_FEATURE_OUT,
  localparam int A_SIZE      = 2 * NUM_FEATURE_OUT,
  localparam int WGT_DEPTH   = W_SIZE + A_SIZE,
  localparam int WGT_ADDR_W  = (WGT_DEPTH > 1) ? $clog2(WGT_DEPTH) : 1,
  localparam int FEAT_ADDR_W = (NUM_FEATURE_IN > 1) ? $clog2(NUM_FEATURE_IN) : 1
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      w_vld,
  output logic                                      w_rdy,
  output logic [WGT_ADDR_W-1:0]                     wgt_rd_addr,
  input  gat_pkg::data_t                            wgt_rd_data,
  input  logic [FEAT_ADDR_W-1:0]                    col_rd_addr,
  output gat_pkg::data_t [NUM_FEATURE_OUT-1:0]      col_rd_data,
  output gat_pkg::data_t [2*NUM_FEATURE_OUT-1:0]    a_vec
);

  localparam int COL_W   = (NUM_FEATURE_OUT > 1) ? $clog2(NUM_FEATURE_OUT) : 1;
  localparam int A_IDX_W = $clog2(A_SIZE);

  gat_pkg::loader_state_e state_q, state_d;

  logic [WGT_ADDR_W-1:0]  rd_addr_q;
  logic                   addr_end_q;
  logic                   issue;
  logic [FEAT_ADDR_W-1:0] row_q;
  logic [COL_W-1:0]       col_q;

  // Destination info, one cycle behind the read address
  logic                   wr_vld_q;
  logic [WGT_ADDR_W-1:0]  wr_addr_q;
  logic [FEAT_ADDR_W-1:0] wr_row_q;
  logic [COL_W-1:0]       wr_col_q;
  logic                   wr_is_a;
  logic                   wr_last;
  logic [A_IDX_W-1:0]     wr_a_idx;

  gat_pkg::data_t [A_SIZE-1:0] a_q;
  logic                        w_rdy_q;

  // ==========================================================================
  // Address sequencing
  // ==========================================================================
  assign issue = w_vld && ((state_q == gat_pkg::IDLE) ||
                           (state_q == gat_pkg::LOAD && !addr_end_q));

  always_comb begin
    state_d = state_q;
    case (state_q)
      gat_pkg::IDLE: if (w_vld) state_d = gat_pkg::LOAD;
      gat_pkg::LOAD: if (wr_vld_q && wr_last) state_d = gat_pkg::DONE;
      default:       state_d = gat_pkg::DONE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= gat_pkg::IDLE;
      rd_addr_q  <= '0;
      addr_end_q <= 1'b0;
      row_q      <= '0;
      col_q      <= '0;
      wr_vld_q   <= 1'b0;
      wr_addr_q  <= '0;
      wr_row_q   <= '0;
      wr_col_q   <= '0;
      w_rdy_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      wr_vld_q <= issue;
      w_rdy_q  <= (state_q == gat_pkg::DONE);
      if (issue) begin
        wr_addr_q <= rd_addr_q;
        wr_row_q  <= row_q;
        wr_col_q  <= col_q;
        if (rd_addr_q == WGT_ADDR_W'(WGT_DEPTH - 1)) begin
          addr_end_q <= 1'b1;
        end else begin
          rd_addr_q <= rd_addr_q + 1'b1;
        end
        // Row and column of the W entry being read
        if (col_q == COL_W'(NUM_FEATURE_OUT - 1)) begin
          col_q <= '0;
          row_q <= row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  assign wr_is_a  = (wr_addr_q >= WGT_ADDR_W'(W_SIZE));
  assign wr_last  = (wr_addr_q == WGT_ADDR_W'(WGT_DEPTH - 1));
  assign wr_a_idx = A_IDX_W'(wr_addr_q - WGT_ADDR_W'(W_SIZE));

  // ==========================================================================
  // Column memories, one per output feature
  // ==========================================================================
  for (genvar c = 0; c < NUM_FEATURE_OUT; c++) begin : g_col
    wgt_bram #(
      .DATA_W (gat_pkg::DATA_WIDTH),
      .DEPTH  (NUM_FEATURE_IN)
    ) col_bram_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (wr_vld_q && !wr_is_a && (wr_col_q == COL_W'(c))),
      .wr_addr (wr_row_q),
      .wr_data (wgt_rd_data),
      .rd_addr (col_rd_addr),
      .rd_data (col_rd_data[c])
    );
  end

  // Attention vector capture
  always_ff @(posedge clk) begin
    if (wr_vld_q && wr_is_a) begin
      a_q[wr_a_idx] <= wgt_rd_data;
    end
  end

  assign wgt_rd_addr = rd_addr_q;
  assign a_vec       = a_q;
  assign w_rdy       = w_rdy_q;

endmodule

// ==== source/wh_sparse_mult.sv ====
// Sparse H row times W multiplier
`timescale 1ns/100ps

module wh_sparse_mult #(
  parameter int NUM_FEATURE_IN  = 8,
  parameter int NUM_FEATURE_OUT = 4,
  localparam int FEAT_ADDR_W = (NUM_FEATURE_IN > 1) ? $clog2(NUM_FEATURE_IN) : 1
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 h_vld,
  input  gat_pkg::h_elem_t                     h_elem,
  output logic [FEAT_ADDR_W-1:0]               col_rd_addr,
  input  gat_pkg::data_t [NUM_FEATURE_OUT-1:0] col_rd_data,
  output logic                                 wh_vld,
  output gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]   wh
);

  // Stage one
  logic           vld_q;
  logic           last_q;
  gat_pkg::data_t value_q;

  // Stage two
  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0] prod;
  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0] sum;
  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0] acc_q;
  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0] wh_q;
  logic                               wh_vld_q;

  // ==========================================================================
  // Stage one: row lookup
  // ==========================================================================
  // Column index addresses every column memory at once, the memory
  // registers it, so data lines up with the delayed value below
  assign col_rd_addr = h_elem.col_idx[FEAT_ADDR_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= 1'b0;
      last_q <= 1'b0;
    end else begin
      vld_q  <= h_vld;
      last_q <= h_vld && h_elem.last;
    end
  end

  always_ff @(posedge clk) begin
    if (h_vld) begin
      value_q <= h_elem.value;
    end
  end

  // ==========================================================================
  // Stage two: multiply and accumulate
  // ==========================================================================
  always_comb begin
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      prod[f] = $signed(value_q) * $signed(col_rd_data[f]);
      sum[f]  = acc_q[f] + prod[f];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q    <= '0;
      wh_vld_q <= 1'b0;
    end else begin
      wh_vld_q <= vld_q && last_q;
      if (vld_q) begin
        // Last element closes the node, next node starts from zero
        if (last_q) begin
          acc_q <= '0;
        end else begin
          acc_q <= sum;
        end
      end
    end
  end

  // Finished node vector
  always_ff @(posedge clk) begin
    if (vld_q && last_q) begin
      wh_q <= sum;
    end
  end

  assign wh_vld = wh_vld_q;
  assign wh     = wh_q;

endmodule

// ==== source/attn_score.sv ====
// Attention half-score unit
`timescale 1ns/100ps

module attn_score #(
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   wh_vld,
  input  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]     wh,
  input  gat_pkg::data_t [2*NUM_FEATURE_OUT-1:0] a_vec,
  output logic                                   score_vld,
  output gat_pkg::score_t                        e_src,
  output gat_pkg::score_t                        e_dst
);

  gat_pkg::score_t src_sum;
  gat_pkg::score_t dst_sum;

  // ==========================================================================
  // Dot products with both halves of a
  // ==========================================================================
  // Lower half of a weighs the source node, upper half the destination
  always_comb begin
    src_sum = '0;
    dst_sum = '0;
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      src_sum = src_sum + gat_pkg::score_t'($signed(wh[f])) *
                          gat_pkg::score_t'($signed(a_vec[f]));
      dst_sum = dst_sum + gat_pkg::score_t'($signed(wh[f])) *
                          gat_pkg::score_t'($signed(a_vec[f + NUM_FEATURE_OUT]));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      score_vld <= 1'b0;
    end else begin
      score_vld <= wh_vld;
    end
  end

  // Scores held until the next node
  always_ff @(posedge clk) begin
    if (wh_vld) begin
      e_src <= src_sum;
      e_dst <= dst_sum;
    end
  end

endmodule

// ==== source/gat_weight_stage.sv ====
// GAT weight preparation and transform stage
`timescale 1ns/100ps

module gat_weight_stage #(
  parameter int NUM_FEATURE_IN  = 8,
  parameter int NUM_FEATURE_OUT = 4,
  localparam int WGT_DEPTH   = NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT,
  localparam int WGT_ADDR_W  = (WGT_DEPTH > 1) ? $clog2(WGT_DEPTH) : 1,
  localparam int FEAT_ADDR_W = (NUM_FEATURE_IN > 1) ? $clog2(NUM_FEATURE_IN) : 1
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wgt_wr_en,
  input  logic [WGT_ADDR_W-1:0]              wgt_wr_addr,
  input  gat_pkg::data_t                     wgt_wr_data,
  input  logic                               w_vld,
  output logic                               w_rdy,
  input  logic                               h_vld,
  input  gat_pkg::h_elem_t                   h_elem,
  output logic                               wh_vld,
  output gat_pkg::wh_t [NUM_FEATURE_OUT-1:0] wh,
  output logic                               score_vld,
  output gat_pkg::score_t                    e_src,
  output gat_pkg::score_t                    e_dst
);

  logic [WGT_ADDR_W-1:0]                  wgt_rd_addr;
  gat_pkg::data_t                         wgt_rd_data;
  logic [FEAT_ADDR_W-1:0]                 col_rd_addr;
  gat_pkg::data_t [NUM_FEATURE_OUT-1:0]   col_rd_data;
  gat_pkg::data_t [2*NUM_FEATURE_OUT-1:0] a_vec;

  // ==========================================================================
  // Host-loaded weight memory, W then a
  // ==========================================================================
  wgt_bram #(
    .DATA_W (gat_pkg::DATA_WIDTH),
    .DEPTH  (WGT_DEPTH)
  ) wgt_bram_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wgt_wr_en),
    .wr_addr (wgt_wr_addr),
    .wr_data (wgt_wr_data),
    .rd_addr (wgt_rd_addr),
    .rd_data (wgt_rd_data)
  );

  w_loader #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) w_loader_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .w_vld       (w_vld),
    .w_rdy       (w_rdy),
    .wgt_rd_addr (wgt_rd_addr),
    .wgt_rd_data (wgt_rd_data),
    .col_rd_addr (col_rd_addr),
    .col_rd_data (col_rd_data),
    .a_vec       (a_vec)
  );

  wh_sparse_mult #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) wh_sparse_mult_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .h_vld       (h_vld),
    .h_elem      (h_elem),
    .col_rd_addr (col_rd_addr),
    .col_rd_data (col_rd_data),
    .wh_vld      (wh_vld),
    .wh          (wh)
  );

  attn_score #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) attn_score_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wh_vld    (wh_vld),
    .wh        (wh),
    .a_vec     (a_vec),
    .score_vld (score_vld),
    .e_src     (e_src),
    .e_dst     (e_dst)
  );

endmodule

// ==== dv/gat_weight_stage_checker.sv ====
// Weight stage protocol assertions
`timescale 1ns/100ps

module gat_weight_stage_checker (
  input logic clk,
  input logic rst_n,
  input logic w_rdy,
  input logic h_vld,
  input logic wh_vld,
  input logic score_vld
);

  // Score register sits one cycle behind the multiplier output
  score_after_wh: assert property (
    @(posedge clk) disable iff (!rst_n) wh_vld |=> score_vld
  ) else $error("score_vld did not follow wh_vld by one cycle");

  // Ready holds until reset once set
  rdy_stays_high: assert property (
    @(posedge clk) disable iff (!rst_n) w_rdy |=> w_rdy
  ) else $error("w_rdy fell after rising");

  // Host may only send H once the weights are split
  h_after_rdy: assert property (
    @(posedge clk) disable iff (!rst_n) h_vld |-> w_rdy
  ) else $error("h_vld seen while w_rdy is low");

endmodule

bind gat_weight_stage gat_weight_stage_checker gat_weight_stage_checker_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .w_rdy     (w_rdy),
  .h_vld     (h_vld),
  .wh_vld    (wh_vld),
  .score_vld (score_vld)
);

// ==== dv/tb_gat_weight_stage.sv ====
// GAT weight stage testbench
`timescale 1ns/100ps

module tb_gat_weight_stage;

  localparam int NI           = 8;
  localparam int NO           = 4;
  localparam int WGT_DEPTH    = NI * NO + 2 * NO;
  localparam int WGT_ADDR_W   = $clog2(WGT_DEPTH);
  localparam int CLK_PERIOD   = 100;
  localparam int NUM_NODES    = 40;
  localparam int MAX_NODE_LEN = 8;
  // Host writes plus the split latency
  localparam int LOAD_CYCLES  = 2 * WGT_DEPTH + 2;
  // Every element plus one possible idle slot per node
  localparam int MAX_ELEMS    = 1 + NUM_NODES * MAX_NODE_LEN + NUM_NODES;
  localparam int WATCHDOG_CYCLES = LOAD_CYCLES + MAX_ELEMS + 50;

  logic                      clk;
  logic                      rst_n;
  logic                      wgt_wr_en;
  logic [WGT_ADDR_W-1:0]     wgt_wr_addr;
  gat_pkg::data_t            wgt_wr_data;
  logic                      w_vld;
  logic                      w_rdy;
  logic                      h_vld;
  gat_pkg::h_elem_t          h_elem;
  logic                      wh_vld;
  gat_pkg::wh_t [NO-1:0]     wh;
  logic                      score_vld;
  gat_pkg::score_t           e_src;
  gat_pkg::score_t           e_dst;

  // Reference copies of the layer parameters and the current node
  gat_pkg::data_t w_ref [NI][NO];
  gat_pkg::data_t a_ref [2*NO];
  gat_pkg::data_t node_val [MAX_NODE_LEN];
  int             node_col [MAX_NODE_LEN];

  gat_pkg::wh_t [NO-1:0] exp_wh_q [$];
  gat_pkg::score_t       exp_src_q [$];
  gat_pkg::score_t       exp_dst_q [$];
  int                    last_cycle_q [$];

  integer seed = 89624;
  int     cycle = 0;
  int     wh_cycle = 0;
  int     errors = 0;
  int     nodes_sent = 0;
  int     score_count = 0;

  gat_weight_stage #(
    .NUM_FEATURE_IN  (NI),
    .NUM_FEATURE_OUT (NO)
  ) gat_weight_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_wr_en   (wgt_wr_en),
    .wgt_wr_addr (wgt_wr_addr),
    .wgt_wr_data (wgt_wr_data),
    .w_vld       (w_vld),
    .w_rdy       (w_rdy),
    .h_vld       (h_vld),
    .h_elem      (h_elem),
    .wh_vld      (wh_vld),
    .wh          (wh),
    .score_vld   (score_vld),
    .e_src       (e_src),
    .e_dst       (e_dst)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // ==========================================================================
  // Reference model
  // ==========================================================================
  // Feature f of WH for the node held in node_val and node_col
  function automatic gat_pkg::wh_t wh_feature(int f, int n);
    longint acc;
    acc = 0;
    for (int i = 0; i < n; i++) begin
      acc += longint'(node_val[i]) * longint'(w_ref[node_col[i]][f]);
    end
    return gat_pkg::wh_t'(acc);
  endfunction

  // Dot product of WH with the half of a starting at base
  function automatic gat_pkg::score_t half_score(gat_pkg::wh_t [NO-1:0] v, int base);
    longint acc;
    acc = 0;
    for (int f = 0; f < NO; f++) begin
      acc += longint'($signed(v[f])) * longint'(a_ref[base + f]);
    end
    return gat_pkg::score_t'(acc);
  endfunction

  // ==========================================================================
  // Stimulus tasks
  // ==========================================================================
  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      h_vld = 1'b0;
    end
  endtask

  task automatic send_node(int n);
    gat_pkg::wh_t [NO-1:0] exp;
    for (int i = 0; i < n; i++) begin
      node_val[i] = gat_pkg::data_t'($random(seed));
      node_col[i] = {$random(seed)} % NI;
    end
    for (int f = 0; f < NO; f++) begin
      exp[f] = wh_feature(f, n);
    end
    exp_wh_q.push_back(exp);
    exp_src_q.push_back(half_score(exp, 0));
    exp_dst_q.push_back(half_score(exp, NO));
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
      h_vld          = 1'b1;
      h_elem.value   = node_val[i];
      h_elem.col_idx = node_col[i][gat_pkg::COL_IDX_WIDTH-1:0];
      h_elem.last    = (i == n - 1);
    end
    nodes_sent++;
  endtask

  // ==========================================================================
  // Compare process, sampled on the falling edge
  // ==========================================================================
  task automatic check_wh();
    gat_pkg::wh_t [NO-1:0] exp;
    int sent_cycle;
    if (exp_wh_q.size() == 0 || last_cycle_q.size() == 0) begin
      $display("Unexpected wh_vld pulse at cycle %0d", cycle);
      errors++;
    end else begin
      exp = exp_wh_q.pop_front();
      sent_cycle = last_cycle_q.pop_front();
      if (cycle != sent_cycle + 2) begin
        $display("wh_vld came %0d cycles after the last element instead of 2",
                 cycle - sent_cycle);
        errors++;
      end
      for (int f = 0; f < NO; f++) begin
        if (wh[f] !== exp[f]) begin
          $display("MISMATCH wh[%0d]: expected %h, got %h", f, exp[f], wh[f]);
          errors++;
        end
      end
    end
    wh_cycle = cycle;
  endtask

  task automatic check_scores();
    gat_pkg::score_t exp_src;
    gat_pkg::score_t exp_dst;
    score_count++;
    if (exp_src_q.size() == 0) begin
      $display("Unexpected score_vld pulse at cycle %0d", cycle);
      errors++;
    end else begin
      exp_src = exp_src_q.pop_front();
      exp_dst = exp_dst_q.pop_front();
      if (cycle != wh_cycle + 1) begin
        $display("score_vld came %0d cycles after wh_vld instead of 1", cycle - wh_cycle);
        errors++;
      end
      if (e_src !== exp_src) begin
        $display("MISMATCH e_src: expected %h, got %h", exp_src, e_src);
        errors++;
      end
      if (e_dst !== exp_dst) begin
        $display("MISMATCH e_dst: expected %h, got %h", exp_dst, e_dst);
        errors++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (h_vld && h_elem.last) begin
        last_cycle_q.push_back(cycle);
      end
      // Scores pair with the previous wh_vld and are checked first
      if (score_vld) begin
        check_scores();
      end
      if (wh_vld) begin
        check_wh();
      end
    end
  end

  // Watchdog sized from the load and the element count
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles with %0d of %0d nodes scored",
             WATCHDOG_CYCLES, score_count, nodes_sent);
    $display("Verification failed");
    $finish;
  end

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    gat_pkg::data_t data;
    clk         = 1'b0;
    rst_n       = 1'b0;
    wgt_wr_en   = 1'b0;
    wgt_wr_addr = '0;
    wgt_wr_data = '0;
    w_vld       = 1'b0;
    h_vld       = 1'b0;
    h_elem      = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (w_rdy || wh_vld || score_vld) begin
      $display("Outputs not low after reset");
      errors++;
    end

    // Host fills the weight memory, W rows first, then a
    for (int addr = 0; addr < WGT_DEPTH; addr++) begin
      data = gat_pkg::data_t'($random(seed));
      if (addr < NI * NO) begin
        w_ref[addr / NO][addr % NO] = data;
      end else begin
        a_ref[addr - NI * NO] = data;
      end
      @(posedge clk);
      #1;
      wgt_wr_en   = 1'b1;
      wgt_wr_addr = WGT_ADDR_W'(addr);
      wgt_wr_data = data;
    end
    @(posedge clk);
    #1;
    wgt_wr_en = 1'b0;
    w_vld     = 1'b1;
    while (!w_rdy) begin
      @(posedge clk);
      #1;
    end
    w_vld = 1'b0;

    // Single element node, then random nodes mostly back to back
    send_node(1);
    idle_cycles(4);
    for (int n = 0; n < NUM_NODES; n++) begin
      send_node(1 + {$random(seed)} % MAX_NODE_LEN);
      if ({$random(seed)} % 4 == 0) begin
        idle_cycles(1);
      end
    end
    idle_cycles(1);
    while (score_count < nodes_sent) @(negedge clk);
    idle_cycles(4);

    if (!w_rdy) begin
      $display("w_rdy dropped before the end of the run");
      errors++;
    end
    if (score_count != nodes_sent || exp_wh_q.size() != 0) begin
      $display("Sent %0d nodes but received %0d scores", nodes_sent, score_count);
      errors++;
    end
    $display("Errors: %0d, nodes sent: %0d, scores received: %0d",
             errors, nodes_sent, score_count);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== gat_weight_stage.f ====
source/gat_pkg.sv
source/wgt_bram.sv
source/w_loader.sv
source/wh_sparse_mult.sv
source/attn_score.sv
source/gat_weight_stage.sv
dv/gat_weight_stage_checker.sv
dv/tb_gat_weight_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the weight stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gat_weight_stage \
  -f gat_weight_stage.f \
  -o sim_gat_weight_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_gat_weight_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
